//--- flist.f
hdl/llc_pkg.sv
hdl/llc_tag_state_array.sv
hdl/llc_evict_ptr.sv
hdl/llc_lookup_way.sv
hdl/llc_ctrl.sv
hdl/llc_lookup_top.sv
testbench/llc_lookup_checker.sv
testbench/tb_llc_lookup.sv

//--- run.sh
#!/bin/sh
# Build and run the LLC lookup testbench with Verilator.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_llc_lookup -f flist.f -o tb_llc_lookup \
    && ./obj_dir/tb_llc_lookup +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qs "^Test passed$" sim.log && echo "run: pass" && exit 0 \
    || { echo "run: fail"; exit 1; }

//--- testbench/tb_llc_lookup.sv
`timescale 1ns/1ps

module tb_llc_lookup;

    import llc_pkg::*;

    localparam int RAND_REQS = 200;
    localparam int MAX_REQS  = RAND_REQS + 60;
    // Four cycles per request, plus reset and drain.
    localparam int TIMEOUT_CYCLES = MAX_REQS * 4 + 100;

    logic      clk;
    logic      rst;
    logic      req_valid;
    llc_req_t  req;
    logic      resp_valid;
    llc_resp_t resp;

    // Reference model of the cache directory.
    llc_tag_t   m_tag   [LLC_SETS][LLC_WAYS];
    llc_state_t m_state [LLC_SETS][LLC_WAYS];
    llc_way_t   m_ptr   [LLC_SETS];

    logic [31:0] rng;
    int          cycles = 0;
    int          errors;
    int          checks;
    int          tests;

    llc_lookup_top dut (.clk, .rst, .req_valid, .req, .resp_valid, .resp);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the DUT stopped responding", cycles);
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic expect_equal(input string name, input int got, input int exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("FAIL %0t %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    // First valid way from the pointer, then first non-SD way, then the pointer.
    function automatic int pick_victim(input llc_set_t set);
        llc_way_t w;
        for (int k = 0; k < LLC_WAYS; k++) begin
            w = m_ptr[set] + llc_way_t'(k);
            if (m_state[set][w] == LLC_VALID) begin
                return int'(w);
            end
        end
        for (int k = 0; k < LLC_WAYS; k++) begin
            w = m_ptr[set] + llc_way_t'(k);
            if (m_state[set][w] != LLC_SD) begin
                return int'(w);
            end
        end
        return int'(m_ptr[set]);
    endfunction

    task automatic send_request(input llc_op_t op, input llc_set_t set, input llc_tag_t tag,
                                input llc_state_t fill, input bit poke);
        int hit_way;
        int exp_way;
        bit exp_evict;
        hit_way   = -1;
        exp_way   = -1;
        exp_evict = 1'b0;
        for (int i = LLC_WAYS - 1; i >= 0; i--) begin
            if (m_state[set][i] != LLC_INVALID && m_tag[set][i] == tag) begin
                hit_way = i;
            end
        end
        if (hit_way >= 0) begin
            exp_way = hit_way;
        end else if (op == LLC_OP_LOOKUP) begin
            for (int i = LLC_WAYS - 1; i >= 0; i--) begin
                if (m_state[set][i] == LLC_INVALID) begin
                    exp_way = i;
                end
            end
            if (exp_way < 0) begin
                exp_evict = 1'b1;
                exp_way   = pick_victim(set);
            end
        end
        req_valid      = 1'b1;
        req.op         = op;
        req.set        = set;
        req.tag        = tag;
        req.fill_state = fill;
        @(negedge clk);
        req_valid = 1'b0;
        if (poke) begin
            // Strobe while busy, to be ignored.
            rng       = xorshift(rng);
            req       = rng[18:0];
            req_valid = 1'b1;
            @(negedge clk);
            req_valid = 1'b0;
        end
        while (!resp_valid) begin
            @(negedge clk);
        end
        expect_equal("resp.hit", int'(resp.hit), (hit_way >= 0) ? 1 : 0);
        expect_equal("resp.evict", int'(resp.evict), int'(exp_evict));
        if (exp_way >= 0) begin
            expect_equal("resp.way", int'(resp.way), exp_way);
        end
        if (exp_evict) begin
            expect_equal("resp.victim_tag", int'(resp.victim_tag),
                         int'(m_tag[set][exp_way]));
            expect_equal("resp.victim_state", int'(resp.victim_state),
                         int'(m_state[set][exp_way]));
        end
        if (hit_way >= 0 && op == LLC_OP_INVAL) begin
            m_state[set][hit_way] = LLC_INVALID;
        end
        if (hit_way < 0 && op == LLC_OP_LOOKUP) begin
            m_tag[set][exp_way]   = tag;
            m_state[set][exp_way] = fill;
            if (exp_evict) begin
                m_ptr[set] = llc_way_t'(exp_way + 1);
            end
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests++;
        $display("%-10s done, %0d errors", name, errors - err_before);
    endtask

    initial begin
        int         e;
        llc_op_t    op;
        llc_tag_t   tag;
        llc_state_t fill;
        clk       = 1'b0;
        rst       = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        rng       = 32'he010;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        for (int s = 0; s < LLC_SETS; s++) begin
            m_ptr[s] = '0;
            for (int w = 0; w < LLC_WAYS; w++) begin
                m_tag[s][w]   = '0;
                m_state[s][w] = LLC_INVALID;
            end
        end
        repeat (10) @(negedge clk);
        rst = 1'b1;
        @(negedge clk);

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Directed tests.
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        e = errors;
        send_request(LLC_OP_LOOKUP, 4'd0, 12'h100, LLC_VALID, 1'b0);
        send_request(LLC_OP_LOOKUP, 4'd0, 12'h100, LLC_SHARED, 1'b0);
        send_request(LLC_OP_LOOKUP, 4'd0, 12'h100, LLC_SD, 1'b0);
        report_test("hit", e);

        e = errors;
        for (int i = 0; i < 3; i++) begin
            send_request(LLC_OP_LOOKUP, 4'd1, llc_tag_t'(12'h200 + i), LLC_VALID, i == 1);
        end
        report_test("alloc", e);

        // Way 0 shared, so the first valid way from pointer 0 is way 1.
        e = errors;
        for (int i = 0; i < LLC_WAYS; i++) begin
            fill = (i == 0) ? LLC_SHARED : LLC_VALID;
            send_request(LLC_OP_LOOKUP, 4'd2, llc_tag_t'(12'h400 + i), fill, 1'b0);
        end
        send_request(LLC_OP_LOOKUP, 4'd2, 12'h480, LLC_VALID, 1'b0);
        send_request(LLC_OP_LOOKUP, 4'd2, 12'h481, LLC_VALID, 1'b0);
        report_test("evict", e);

        e = errors;
        for (int i = 0; i < LLC_WAYS; i++) begin
            fill = (i == 2 || i == 4) ? LLC_SHARED : LLC_SD;
            send_request(LLC_OP_LOOKUP, 4'd3, llc_tag_t'(12'h500 + i), fill, 1'b0);
            send_request(LLC_OP_LOOKUP, 4'd4, llc_tag_t'(12'h580 + i), LLC_SD, 1'b0);
        end
        send_request(LLC_OP_LOOKUP, 4'd3, 12'h540, LLC_SD, 1'b0);
        send_request(LLC_OP_LOOKUP, 4'd3, 12'h541, LLC_SD, 1'b0);
        send_request(LLC_OP_LOOKUP, 4'd4, 12'h5c0, LLC_SD, 1'b0);
        send_request(LLC_OP_LOOKUP, 4'd4, 12'h5c1, LLC_SD, 1'b1);
        report_test("sd_mix", e);

        e = errors;
        for (int i = 0; i < 3; i++) begin
            send_request(LLC_OP_LOOKUP, 4'd5, llc_tag_t'(12'h600 + i), LLC_VALID, 1'b0);
        end
        send_request(LLC_OP_INVAL, 4'd5, 12'h601, LLC_VALID, 1'b0);
        send_request(LLC_OP_INVAL, 4'd5, 12'h601, LLC_VALID, 1'b0);
        send_request(LLC_OP_INVAL, 4'd5, 12'h6ff, LLC_VALID, 1'b0);
        send_request(LLC_OP_LOOKUP, 4'd5, 12'h610, LLC_VALID, 1'b0);
        // Missing invalidate in a full set leaves the victim and pointer alone.
        send_request(LLC_OP_INVAL, 4'd2, 12'h6ff, LLC_VALID, 1'b0);
        send_request(LLC_OP_LOOKUP, 4'd2, 12'h482, LLC_VALID, 1'b0);
        report_test("inval", e);

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Random traffic over four sets.
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        e = errors;
        for (int n = 0; n < RAND_REQS; n++) begin
            rng  = xorshift(rng);
            op   = (rng[1:0] == 2'b00) ? LLC_OP_INVAL : LLC_OP_LOOKUP;
            tag  = {8'h30, rng[7:4]};
            fill = (rng[9:8] == 2'b00) ? LLC_VALID : llc_state_t'(rng[9:8]);
            send_request(op, llc_set_t'(rng[3:2]), tag, fill, rng[10] & rng[11]);
        end
        report_test("random", e);

        repeat (3) @(negedge clk);
        $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
                 tests, checks, errors, dut.chk.fail_cnt);
        if (errors == 0 && dut.chk.fail_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- testbench/llc_lookup_checker.sv
`timescale 1ns/1ps

module llc_lookup_checker (
    input logic               clk,
    input logic               rst,
    input logic               rd_en,
    input logic               resp_valid,
    input llc_pkg::llc_resp_t resp
);

    int fail_cnt = 0;

    // Strobe sampled at edge 0, response sampled high at edge 4.
    a_resp_delay: assert property (@(posedge clk) disable iff (!rst)
        resp_valid == $past(rd_en, 4))
        else begin
            $error("resp_valid does not follow an accepted request by three cycles");
            fail_cnt++;
        end

    a_resp_single: assert property (@(posedge clk) disable iff (!rst)
        resp_valid |-> !$past(resp_valid))
        else begin
            $error("resp_valid high for two cycles in a row");
            fail_cnt++;
        end

    a_hit_evict: assert property (@(posedge clk) disable iff (!rst)
        resp_valid |-> !(resp.hit && resp.evict))
        else begin
            $error("hit and evict both high in one response");
            fail_cnt++;
        end

    a_reset_quiet: assert property (@(posedge clk) !rst |-> !resp_valid)
        else begin
            $error("resp_valid high during reset");
            fail_cnt++;
        end

endmodule

bind llc_lookup_top llc_lookup_checker chk (
    .clk(clk),
    .rst(rst),
    .rd_en(rd_en),
    .resp_valid(resp_valid),
    .resp(resp)
);

//--- hdl/llc_lookup_top.sv
`timescale 1ns/1ps

module llc_lookup_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               req_valid,
    input  llc_pkg::llc_req_t  req,
    output logic               resp_valid,
    output llc_pkg::llc_resp_t resp
);

    import llc_pkg::*;

    logic            rd_en;
    llc_set_t        rd_set;
    logic            lookup_en;
    llc_tag_t        lookup_tag;
    logic            wr_en;
    llc_set_t        wr_set;
    llc_way_t        wr_way;
    llc_tag_t        wr_tag;
    llc_state_t      wr_state;
    logic            ptr_adv;
    llc_way_t        ptr_next;
    llc_set_tags_t   set_tags;
    llc_set_states_t set_states;
    llc_way_t        evict_ptr;
    llc_way_t        way;
    logic            evict;

    llc_ctrl u_ctrl (
        .clk, .rst, .req_valid, .req,
        .set_tags, .set_states, .way, .evict,
        .rd_en, .rd_set, .lookup_en, .lookup_tag,
        .wr_en, .wr_set, .wr_way, .wr_tag, .wr_state,
        .ptr_adv, .ptr_next, .resp_valid, .resp
    );

    llc_tag_state_array u_array (
        .clk, .rst, .rd_en, .rd_set,
        .wr_en, .wr_set, .wr_way, .wr_tag, .wr_state,
        .set_tags, .set_states
    );

    // The pointer advances in the set that was written.
    llc_evict_ptr u_ptr (
        .clk, .rst, .rd_en, .rd_set,
        .adv(ptr_adv), .adv_set(wr_set), .ptr_next,
        .evict_ptr
    );

    llc_lookup_way u_lookup (
        .clk, .rst, .lookup_en, .tag(lookup_tag),
        .set_tags, .set_states, .evict_ptr,
        .way, .evict
    );

endmodule

//--- hdl/llc_ctrl.sv
`timescale 1ns/1ps

module llc_ctrl (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     req_valid,
    input  llc_pkg::llc_req_t        req,
    input  llc_pkg::llc_set_tags_t   set_tags,
    input  llc_pkg::llc_set_states_t set_states,
    input  llc_pkg::llc_way_t        way,
    input  logic                     evict,
    output logic                     rd_en,
    output llc_pkg::llc_set_t        rd_set,
    output logic                     lookup_en,
    output llc_pkg::llc_tag_t        lookup_tag,
    output logic                     wr_en,
    output llc_pkg::llc_set_t        wr_set,
    output llc_pkg::llc_way_t        wr_way,
    output llc_pkg::llc_tag_t        wr_tag,
    output llc_pkg::llc_state_t      wr_state,
    output logic                     ptr_adv,
    output llc_pkg::llc_way_t        ptr_next,
    output logic                     resp_valid,
    output llc_pkg::llc_resp_t       resp
);

    import llc_pkg::*;

    llc_ctrl_state_t state;
    llc_req_t        req_q;
    llc_set_tags_t   tags_q;
    llc_set_states_t states_q;
    llc_way_t        way_q;
    llc_state_t      wr_state_q;
    logic            hit_q;
    logic            evict_q;
    logic            wr_q;
    logic            hit_c;
    logic            is_lookup;

    assign is_lookup = (req_q.op == LLC_OP_LOOKUP);
    // A hit is a non-victim way holding the requested tag.
    assign hit_c = !evict && (states_q[way] != LLC_INVALID) && (tags_q[way] == req_q.tag);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Datapath controls.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign rd_en      = (state == S_IDLE) && req_valid;
    assign rd_set     = req.set;
    assign lookup_en  = (state == S_READ);
    assign lookup_tag = req_q.tag;
    assign wr_en      = (state == S_UPDATE) && wr_q;
    assign wr_set     = req_q.set;
    assign wr_way     = way_q;
    assign wr_tag     = req_q.tag;
    assign wr_state   = wr_state_q;
    assign ptr_adv    = (state == S_UPDATE) && evict_q;
    assign ptr_next   = way_q + llc_way_t'(1);

    always_ff @(posedge clk) begin
        if (rd_en) begin
            req_q <= req;
        end
        if (state == S_READ) begin
            tags_q   <= set_tags;
            states_q <= set_states;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sequencer and response.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state      <= S_IDLE;
            way_q      <= '0;
            wr_state_q <= LLC_INVALID;
            hit_q      <= 1'b0;
            evict_q    <= 1'b0;
            wr_q       <= 1'b0;
            resp_valid <= 1'b0;
            resp       <= '0;
        end else begin
            resp_valid <= (state == S_UPDATE);
            case (state)
                S_IDLE: begin
                    if (req_valid) begin
                        state <= S_READ;
                    end
                end
                S_READ: state <= S_LOOKUP;
                S_LOOKUP: begin
                    way_q      <= way;
                    hit_q      <= hit_c;
                    evict_q    <= is_lookup && evict;
                    // Lookups fill on a miss, invalidates clear on a hit.
                    wr_q       <= is_lookup ? !hit_c : hit_c;
                    wr_state_q <= is_lookup ? req_q.fill_state : LLC_INVALID;
                    state      <= S_UPDATE;
                end
                S_UPDATE: begin
                    resp.way          <= way_q;
                    resp.hit          <= hit_q;
                    resp.evict        <= evict_q;
                    resp.victim_tag   <= evict_q ? tags_q[way_q] : '0;
                    resp.victim_state <= evict_q ? states_q[way_q] : LLC_INVALID;
                    state             <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

//--- hdl/llc_lookup_way.sv
`timescale 1ns/1ps

module llc_lookup_way (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     lookup_en,
    input  llc_pkg::llc_tag_t        tag,
    input  llc_pkg::llc_set_tags_t   set_tags,
    input  llc_pkg::llc_set_states_t set_states,
    input  llc_pkg::llc_way_t        evict_ptr,
    output llc_pkg::llc_way_t        way,
    output logic                     evict
);

    import llc_pkg::*;

    // Lowest set bit, zero when none.
    function automatic llc_way_t first_one(input logic [LLC_WAYS-1:0] v);
        llc_way_t w;
        w = '0;
        for (int i = LLC_WAYS - 1; i >= 0; i--) begin
            if (v[i]) begin
                w = llc_way_t'(i);
            end
        end
        return w;
    endfunction

    logic [LLC_WAYS-1:0] hit_vec;
    logic [LLC_WAYS-1:0] empty_vec;
    logic [LLC_WAYS-1:0] valid_rot;
    logic [LLC_WAYS-1:0] not_sd_rot;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Candidate vectors.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        llc_way_t idx;
        for (int i = 0; i < LLC_WAYS; i++) begin
            hit_vec[i]   = (set_tags[i] == tag) && (set_states[i] != LLC_INVALID);
            empty_vec[i] = (set_states[i] == LLC_INVALID);
            // Bit 0 of the rotated vectors is the pointer way.
            idx = evict_ptr + llc_way_t'(i);
            valid_rot[i]  = (set_states[idx] == LLC_VALID);
            not_sd_rot[i] = (set_states[idx] != LLC_SD);
        end
    end

    llc_way_t way_next;
    logic     evict_next;

    // Hit, then empty, then victim search from the pointer.
    always_comb begin
        if (|hit_vec) begin
            way_next   = first_one(hit_vec);
            evict_next = 1'b0;
        end else if (|empty_vec) begin
            way_next   = first_one(empty_vec);
            evict_next = 1'b0;
        end else if (|valid_rot) begin
            way_next   = evict_ptr + first_one(valid_rot);
            evict_next = 1'b1;
        end else if (|not_sd_rot) begin
            way_next   = evict_ptr + first_one(not_sd_rot);
            evict_next = 1'b1;
        end else begin
            way_next   = evict_ptr;
            evict_next = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            way   <= '0;
            evict <= 1'b0;
        end else if (lookup_en) begin
            way   <= way_next;
            evict <= evict_next;
        end
    end

endmodule

//--- hdl/llc_evict_ptr.sv
`timescale 1ns/1ps

module llc_evict_ptr (
    input  logic              clk,
    input  logic              rst,
    input  logic              rd_en,
    input  llc_pkg::llc_set_t rd_set,
    input  logic              adv,
    input  llc_pkg::llc_set_t adv_set,
    input  llc_pkg::llc_way_t ptr_next,
    output llc_pkg::llc_way_t evict_ptr
);

    import llc_pkg::*;

    // One round-robin pointer per set.
    llc_way_t ptr_mem [LLC_SETS];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < LLC_SETS; s++) begin
                ptr_mem[s] <= '0;
            end
            evict_ptr <= '0;
        end else begin
            if (adv) begin
                ptr_mem[adv_set] <= ptr_next;
            end
            if (rd_en) begin
                evict_ptr <= ptr_mem[rd_set];
            end
        end
    end

endmodule

//--- hdl/llc_tag_state_array.sv
`timescale 1ns/1ps

module llc_tag_state_array (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    rd_en,
    input  llc_pkg::llc_set_t       rd_set,
    input  logic                    wr_en,
    input  llc_pkg::llc_set_t       wr_set,
    input  llc_pkg::llc_way_t       wr_way,
    input  llc_pkg::llc_tag_t       wr_tag,
    input  llc_pkg::llc_state_t     wr_state,
    output llc_pkg::llc_set_tags_t  set_tags,
    output llc_pkg::llc_set_states_t set_states
);

    import llc_pkg::*;

    llc_set_tags_t   tag_mem   [LLC_SETS];
    llc_set_states_t state_mem [LLC_SETS];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Tag storage.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_set][wr_way] <= wr_tag;
        end
        if (rd_en) begin
            set_tags <= tag_mem[rd_set];
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // State storage.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < LLC_SETS; s++) begin
                state_mem[s] <= {LLC_WAYS{LLC_INVALID}};
            end
            set_states <= {LLC_WAYS{LLC_INVALID}};
        end else begin
            // Only one way of a set changes per write.
            if (wr_en) begin
                state_mem[wr_set][wr_way] <= wr_state;
            end
            if (rd_en) begin
                set_states <= state_mem[rd_set];
            end
        end
    end

endmodule

//--- hdl/llc_pkg.sv
package llc_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Cache geometry.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int LLC_WAYS  = 8;
    localparam int LLC_SETS  = 16;
    localparam int LLC_TAG_W = 12;

    typedef logic [LLC_TAG_W-1:0]        llc_tag_t;
    typedef logic [$clog2(LLC_SETS)-1:0] llc_set_t;
    typedef logic [$clog2(LLC_WAYS)-1:0] llc_way_t;

    // Line states.
    typedef logic [1:0] llc_state_t;
    localparam llc_state_t LLC_INVALID = 2'd0;
    localparam llc_state_t LLC_VALID   = 2'd1;
    localparam llc_state_t LLC_SD      = 2'd2;
    localparam llc_state_t LLC_SHARED  = 2'd3;

    typedef llc_tag_t   [LLC_WAYS-1:0] llc_set_tags_t;
    typedef llc_state_t [LLC_WAYS-1:0] llc_set_states_t;

    typedef logic [0:0] llc_op_t;
    localparam llc_op_t LLC_OP_LOOKUP = 1'b0;
    localparam llc_op_t LLC_OP_INVAL  = 1'b1;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Request and response.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        llc_op_t    op;
        llc_set_t   set;
        llc_tag_t   tag;
        llc_state_t fill_state;
    } llc_req_t;

    typedef struct packed {
        llc_way_t   way;
        logic       hit;
        logic       evict;
        llc_tag_t   victim_tag;
        llc_state_t victim_state;
    } llc_resp_t;

    typedef enum logic [1:0] {S_IDLE, S_READ, S_LOOKUP, S_UPDATE} llc_ctrl_state_t;

endpackage
